// File: Bender.yml
package:
  name: epu

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/epu_pkg.sv
      - hdl/weight_sram.sv
      - hdl/weight_wrapper.sv
      - hdl/mac_engine.sv
      - hdl/epu_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/epu_tb.sv

// File: hdl/epu_cfg.svh
`ifndef EPU_CFG_SVH
`define EPU_CFG_SVH

// signed weight stored in the buffer
`define WEIGHT_W 8

// signed activation from the feature path
`define ACT_W 8

// accumulator and result width
// wide enough for 256 full-scale products
`define ACC_W 24

// weight buffer addressing
`define WADDR_W 8
`define WDEPTH 256

// dot-product length, zero is taken as one
`define LEN_W 8

// width of one raw weight x activation product
`define PROD_W (`WEIGHT_W + `ACT_W)

`endif

// File: hdl/epu_pkg.sv
package epu_pkg;

  // who owns the weight SRAM
  typedef enum logic [1:0] {
    MODE_IDLE   = 2'h0,
    MODE_ENGINE = 2'h1,
    MODE_LOAD   = 2'h3
  } buf_mode_e;

  // dot-product engine FSM
  typedef enum logic [1:0] {
    // waiting for start
    ENG_IDLE  = 2'h0,
    // fetching one weight per activation
    ENG_RUN   = 2'h1,
    // last product still in flight
    ENG_DRAIN = 2'h2
  } eng_state_e;

endpackage

// File: hdl/epu_top.sv
`include "epu_cfg.svh"

module epu_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        enb_i,
  // host loader
  input  logic                        load_start_i,
  input  logic                        load_done_i,
  input  logic                        host_cs_i,
  input  logic [`WADDR_W-1:0]         host_addr_i,
  input  logic [`WEIGHT_W-1:0]        host_wdata_i,
  // dot-product job and activations
  input  logic                        start_i,
  input  logic [`WADDR_W-1:0]         base_addr_i,
  input  logic [`LEN_W-1:0]           len_i,
  input  logic                        act_valid_i,
  input  logic signed [`ACT_W-1:0]    act_data_i,
  output logic signed [`ACC_W-1:0]    result_o,
  output logic                        result_valid_o,
  output logic                        busy_o,
  output epu_pkg::buf_mode_e          mode_o
);

  // engine to buffer
  logic                 eng_cs;
  logic [`WADDR_W-1:0]  eng_addr;
  logic [`WEIGHT_W-1:0] eng_rdata;

  weight_wrapper weight_wrapper_i (
    .clk          (clk),
    .rst          (rst),
    .enb_i        (enb_i),
    .load_start_i (load_start_i),
    .load_done_i  (load_done_i),
    .host_cs_i    (host_cs_i),
    .host_addr_i  (host_addr_i),
    .host_wdata_i (host_wdata_i),
    .eng_cs_i     (eng_cs),
    .eng_addr_i   (eng_addr),
    .eng_rdata_o  (eng_rdata),
    .mode_o       (mode_o)
  );

  mac_engine mac_engine_i (
    .clk            (clk),
    .rst            (rst),
    .start_i        (start_i),
    .base_addr_i    (base_addr_i),
    .len_i          (len_i),
    .act_valid_i    (act_valid_i),
    .act_data_i     (act_data_i),
    .w_cs_o         (eng_cs),
    .w_addr_o       (eng_addr),
    .w_rdata_i      (eng_rdata),
    .result_o       (result_o),
    .result_valid_o (result_valid_o),
    .busy_o         (busy_o)
  );

endmodule

// File: hdl/mac_engine.sv
`include "epu_cfg.svh"

module mac_engine (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        start_i,
  input  logic [`WADDR_W-1:0]         base_addr_i,
  input  logic [`LEN_W-1:0]           len_i,
  input  logic                        act_valid_i,
  input  logic signed [`ACT_W-1:0]    act_data_i,
  // weight buffer read port
  output logic                        w_cs_o,
  output logic [`WADDR_W-1:0]         w_addr_o,
  input  logic signed [`WEIGHT_W-1:0] w_rdata_i,
  // dot-product result
  output logic signed [`ACC_W-1:0]    result_o,
  output logic                        result_valid_o,
  output logic                        busy_o
);

  import epu_pkg::*;

  eng_state_e state_q;

  // job parameters latched on start
  logic [`WADDR_W-1:0] base_q;
  logic [`LEN_W-1:0]   last_idx_q;

  // activations accepted so far
  logic [`LEN_W-1:0] cnt_q;

  logic act_take;
  logic act_last;

  // stage 1 waits for the weight
  logic                     v1_q;
  logic                     last1_q;
  logic signed [`ACT_W-1:0] act_q;

  // stage 2 marks the last product added
  logic last2_q;

  logic signed [`PROD_W-1:0] prod;
  logic signed [`ACC_W-1:0]  prod_ext;
  logic signed [`ACC_W-1:0]  acc_q;
  logic                      result_valid_q;

  assign act_take = (state_q == ENG_RUN) && act_valid_i;
  assign act_last = (cnt_q == last_idx_q);

  // read goes out on the edge that takes the activation
  assign w_cs_o   = act_take;
  assign w_addr_o = base_q + `WADDR_W'(cnt_q);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q <= ENG_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        ENG_IDLE: begin
          if (start_i) begin
            state_q <= ENG_RUN;
            cnt_q   <= '0;
          end
        end
        ENG_RUN: begin
          if (act_take) begin
            cnt_q <= cnt_q + 1'b1;
            if (act_last) begin
              state_q <= ENG_DRAIN;
            end
          end
        end
        ENG_DRAIN: begin
          // last product lands one edge before this
          if (last2_q) begin
            state_q <= ENG_IDLE;
          end
        end
        default: state_q <= ENG_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state_q == ENG_IDLE) && start_i) begin
      base_q     <= base_addr_i;
      last_idx_q <= (len_i == '0) ? '0 : len_i - 1'b1;
    end
  end

  // line activation up with the returning weight
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      v1_q    <= 1'b0;
      last1_q <= 1'b0;
      last2_q <= 1'b0;
    end else begin
      v1_q    <= act_take;
      last1_q <= act_take && act_last;
      last2_q <= last1_q;
    end
  end

  always_ff @(posedge clk) begin
    if (act_take) begin
      act_q <= act_data_i;
    end
  end

  assign prod     = w_rdata_i * act_q;
  assign prod_ext = {{(`ACC_W - `PROD_W){prod[`PROD_W-1]}}, prod};

  // cleared on each accepted start and held afterwards
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      acc_q <= '0;
    end else if ((state_q == ENG_IDLE) && start_i) begin
      acc_q <= '0;
    end else if (v1_q) begin
      acc_q <= acc_q + prod_ext;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      result_valid_q <= 1'b0;
    end else begin
      result_valid_q <= (state_q == ENG_DRAIN) && last2_q;
    end
  end

  assign result_o       = acc_q;
  assign result_valid_o = result_valid_q;
  assign busy_o         = (state_q != ENG_IDLE);

endmodule

// File: hdl/weight_sram.sv
`include "epu_cfg.svh"

module weight_sram (
  input  logic                  clk,
  input  logic                  cs_i,
  input  logic                  we_i,
  input  logic [`WADDR_W-1:0]   addr_i,
  input  logic [`WEIGHT_W-1:0]  wdata_i,
  output logic [`WEIGHT_W-1:0]  rdata_o
);

  // weight storage, contents undefined until loaded
  logic [`WEIGHT_W-1:0] mem [`WDEPTH];

  // read data register, holds between reads
  logic [`WEIGHT_W-1:0] rdata_q;

  always_ff @(posedge clk) begin
    if (cs_i && we_i) begin
      mem[addr_i] <= wdata_i;
    end
  end

  // one cycle read latency
  // a write cycle leaves the read register alone
  always_ff @(posedge clk) begin
    if (cs_i && !we_i) begin
      rdata_q <= mem[addr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: hdl/weight_wrapper.sv
`include "epu_cfg.svh"

module weight_wrapper (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  enb_i,
  // host loader side
  input  logic                  load_start_i,
  input  logic                  load_done_i,
  input  logic                  host_cs_i,
  input  logic [`WADDR_W-1:0]   host_addr_i,
  input  logic [`WEIGHT_W-1:0]  host_wdata_i,
  // engine side, reads only
  input  logic                  eng_cs_i,
  input  logic [`WADDR_W-1:0]   eng_addr_i,
  output logic [`WEIGHT_W-1:0]  eng_rdata_o,
  // ownership status
  output epu_pkg::buf_mode_e    mode_o
);

  import epu_pkg::*;

  buf_mode_e mode_q;
  buf_mode_e mode_d;

  // engine ownership as seen by the data coming back
  logic rd_engine_q;

  logic                 sram_cs;
  logic                 sram_we;
  logic [`WADDR_W-1:0]  sram_addr;
  logic [`WEIGHT_W-1:0] sram_wdata;
  logic [`WEIGHT_W-1:0] sram_rdata;

  weight_sram weight_sram_i (
    .clk     (clk),
    .cs_i    (sram_cs),
    .we_i    (sram_we),
    .addr_i  (sram_addr),
    .wdata_i (sram_wdata),
    .rdata_o (sram_rdata)
  );

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      mode_q <= MODE_IDLE;
    end else begin
      mode_q <= mode_d;
    end
  end

  // mode only moves while enabled
  always_comb begin
    mode_d = mode_q;
    case (mode_q)
      MODE_IDLE: begin
        if (enb_i && load_start_i) begin
          mode_d = MODE_LOAD;
        end
      end
      MODE_LOAD: begin
        if (enb_i && load_done_i) begin
          mode_d = MODE_ENGINE;
        end
      end
      MODE_ENGINE: begin
        // a fresh load takes the buffer back
        if (enb_i && load_start_i) begin
          mode_d = MODE_LOAD;
        end
      end
      default: mode_d = MODE_IDLE;
    endcase
  end

  // SRAM port mux
  always_comb begin
    sram_cs    = 1'b0;
    sram_we    = 1'b0;
    sram_addr  = '0;
    sram_wdata = '0;
    if (mode_q == MODE_ENGINE) begin
      sram_cs   = eng_cs_i;
      sram_addr = eng_addr_i;
    end else if (mode_q == MODE_LOAD) begin
      // every selected host cycle is a write
      sram_cs    = host_cs_i;
      sram_we    = 1'b1;
      sram_addr  = host_addr_i;
      sram_wdata = host_wdata_i;
    end
  end

  // read data lags the request by one cycle
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rd_engine_q <= 1'b0;
    end else begin
      rd_engine_q <= (mode_q == MODE_ENGINE);
    end
  end

  // engine sees zeros unless it owned the buffer at the read
  assign eng_rdata_o = rd_engine_q ? sram_rdata : '0;
  assign mode_o      = mode_q;

endmodule

// File: list.f
+incdir+hdl
hdl/epu_pkg.sv
hdl/weight_sram.sv
hdl/weight_wrapper.sv
hdl/mac_engine.sv
hdl/epu_top.sv
tb/epu_tb.sv

// File: tb/epu_tb.sv
`include "epu_cfg.svh"

module epu_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import epu_pkg::*;

  localparam int MAX_ENTRIES = 24;

  typedef enum logic [1:0] {
    ACT_START,
    ACT_DONE,
    ACT_LOAD,
    ACT_DOT
  } action_e;

  // one row of the stimulus table
  typedef struct packed {
    action_e      action;
    logic         enb;
    logic [7:0]   base;
    logic [8:0]   len;
    // bit k set puts an idle cycle before activation k
    logic [31:0]  gaps;
    // second start while busy
    logic         restart;
    buf_mode_e    exp_mode;
  } entry_t;

  logic                        clk = 1'b0;
  logic                        rst;
  logic                        enb;
  logic                        load_start;
  logic                        load_done;
  logic                        host_cs;
  logic [`WADDR_W-1:0]         host_addr;
  logic [`WEIGHT_W-1:0]        host_wdata;
  logic                        start;
  logic [`WADDR_W-1:0]         base_addr;
  logic [`LEN_W-1:0]           len;
  logic                        act_valid;
  logic signed [`ACT_W-1:0]    act_data;
  logic signed [`ACC_W-1:0]    result;
  logic                        result_valid;
  logic                        busy;
  buf_mode_e                   mode;

  entry_t entries [MAX_ENTRIES];
  int     num_entries = 0;

  // shadow copy of the weight buffer
  logic signed [`WEIGHT_W-1:0] shadow [`WDEPTH];
  buf_mode_e   cur_mode;
  logic [31:0] lcg_state = 32'h6841_885f;

  int cycle_cnt = 0;
  int limit_cycles = 0;

  epu_top epu_top_i (
    .clk            (clk),
    .rst            (rst),
    .enb_i          (enb),
    .load_start_i   (load_start),
    .load_done_i    (load_done),
    .host_cs_i      (host_cs),
    .host_addr_i    (host_addr),
    .host_wdata_i   (host_wdata),
    .start_i        (start),
    .base_addr_i    (base_addr),
    .len_i          (len),
    .act_valid_i    (act_valid),
    .act_data_i     (act_data),
    .result_o       (result),
    .result_valid_o (result_valid),
    .busy_o         (busy),
    .mode_o         (mode)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= limit_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", limit_cycles);
      $display("Verification failed");
      $fatal(1, "timeout");
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_value(input string sig_name, input logic signed [31:0] exp_v,
                             input logic signed [31:0] act_v);
    if (act_v !== exp_v) begin
      $display("Error: time %0t, %s expected %0d, got %0d", $time, sig_name, exp_v, act_v);
      $display("Verification failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic add_entry(input action_e action, input logic enb_v, input int base_v,
                           input int len_v, input logic [31:0] gaps,
                           input logic restart, input buf_mode_e exp_mode);
    entry_t e;
    e.action   = action;
    e.enb      = enb_v;
    e.base     = base_v[7:0];
    e.len      = len_v[8:0];
    e.gaps     = gaps;
    e.restart  = restart;
    e.exp_mode = exp_mode;
    entries[num_entries] = e;
    num_entries++;
  endtask

  task automatic build_table();
    // pulses with enb low first, then the mode walk
    add_entry(ACT_START, 1'b0, 0, 0, 32'h0, 1'b0, MODE_IDLE);
    add_entry(ACT_START, 1'b1, 0, 0, 32'h0, 1'b0, MODE_LOAD);
    add_entry(ACT_DONE, 1'b1, 0, 0, 32'h0, 1'b0, MODE_ENGINE);
    add_entry(ACT_START, 1'b1, 0, 0, 32'h0, 1'b0, MODE_LOAD);
    add_entry(ACT_LOAD, 1'b1, 0, 256, 32'h0, 1'b0, MODE_LOAD);
    add_entry(ACT_DONE, 1'b0, 0, 0, 32'h0, 1'b0, MODE_LOAD);
    add_entry(ACT_DONE, 1'b1, 0, 0, 32'h0, 1'b0, MODE_ENGINE);
    add_entry(ACT_START, 1'b0, 0, 0, 32'h0, 1'b0, MODE_ENGINE);
    // back to back activations
    add_entry(ACT_DOT, 1'b1, 16, 8, 32'h0, 1'b0, MODE_ENGINE);
    add_entry(ACT_DOT, 1'b0, 100, 32, 32'h0, 1'b0, MODE_ENGINE);
    add_entry(ACT_DOT, 1'b1, 3, 1, 32'h0, 1'b0, MODE_ENGINE);
    // zero length runs one item
    add_entry(ACT_DOT, 1'b1, 200, 0, 32'h0, 1'b0, MODE_ENGINE);
    // gaps, then a range wrapping past the last word
    add_entry(ACT_DOT, 1'b1, 40, 12, 32'h0000_0a5a, 1'b0, MODE_ENGINE);
    add_entry(ACT_DOT, 1'b1, 250, 12, 32'h0000_0124, 1'b0, MODE_ENGINE);
    add_entry(ACT_DOT, 1'b1, 60, 10, 32'h0, 1'b1, MODE_ENGINE);
    // reads in load mode come back as zero
    add_entry(ACT_START, 1'b1, 0, 0, 32'h0, 1'b0, MODE_LOAD);
    add_entry(ACT_DOT, 1'b1, 16, 8, 32'h0, 1'b0, MODE_LOAD);
    add_entry(ACT_LOAD, 1'b1, 248, 16, 32'h0, 1'b0, MODE_LOAD);
    add_entry(ACT_DONE, 1'b1, 0, 0, 32'h0, 1'b0, MODE_ENGINE);
    add_entry(ACT_DOT, 1'b1, 244, 20, 32'h0003_0011, 1'b0, MODE_ENGINE);
  endtask

  function automatic int cycle_limit();
    int total;
    total = 40 * num_entries;
    for (int i = 0; i < num_entries; i++) begin
      total += int'(entries[i].len);
    end
    return total;
  endfunction

  task automatic pulse_mode(input entry_t e);
    @(posedge clk);
    enb <= e.enb;
    if (e.action == ACT_START) begin
      load_start <= 1'b1;
    end else begin
      load_done <= 1'b1;
    end
    @(posedge clk);
    load_start <= 1'b0;
    load_done  <= 1'b0;
  endtask

  task automatic load_block(input entry_t e);
    int i;
    logic [`WADDR_W-1:0]  addr;
    logic [`WEIGHT_W-1:0] w;
    @(posedge clk);
    enb <= e.enb;
    for (i = 0; i < int'(e.len); i++) begin
      addr = `WADDR_W'(int'(e.base) + i);
      lcg_state = lcg_next(lcg_state);
      w = lcg_state[23:16];
      host_cs    <= 1'b1;
      host_addr  <= addr;
      host_wdata <= w;
      // writes only land while the host owns the buffer
      if (cur_mode == MODE_LOAD) begin
        shadow[addr] = w;
      end
      @(posedge clk);
    end
    host_cs <= 1'b0;
  endtask

  task automatic dot_product(input entry_t e);
    int n;
    int k;
    int exp_sum;
    int edges;
    logic [`WADDR_W-1:0]      addr;
    logic signed [`ACT_W-1:0] a;
    n = (e.len == 0) ? 1 : int'(e.len);
    exp_sum = 0;
    @(posedge clk);
    enb       <= e.enb;
    start     <= 1'b1;
    base_addr <= e.base;
    len       <= e.len[7:0];
    @(posedge clk);
    // job accepted here, a repeated start must be ignored
    start     <= e.restart;
    base_addr <= e.base ^ 8'h5a;
    len       <= 8'd3;
    @(negedge clk);
    check_value("busy_o", 1, busy);
    for (k = 0; k < n; k++) begin
      @(posedge clk);
      start <= 1'b0;
      if (e.gaps[k]) begin
        act_valid <= 1'b0;
        @(posedge clk);
      end
      lcg_state = lcg_next(lcg_state);
      a = lcg_state[15:8];
      act_valid <= 1'b1;
      act_data  <= a;
      addr = `WADDR_W'(int'(e.base) + k);
      if (cur_mode == MODE_ENGINE) begin
        exp_sum += int'(shadow[addr]) * int'(a);
      end
    end
    // last activation is sampled on this edge
    @(posedge clk);
    act_valid <= 1'b0;
    edges = 0;
    @(negedge clk);
    while (result_valid !== 1'b1) begin
      @(posedge clk);
      edges++;
      @(negedge clk);
    end
    check_value("result_valid_o delay", 2, edges);
    check_value("result_o", exp_sum, result);
    @(negedge clk);
    check_value("result_valid_o", 0, result_valid);
    check_value("busy_o", 0, busy);
    // sum holds until the next start
    check_value("result_o", exp_sum, result);
  endtask

  initial begin
    entry_t e;
    int idx;
    rst        = 1'b1;
    enb        = 1'b0;
    load_start = 1'b0;
    load_done  = 1'b0;
    host_cs    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    start      = 1'b0;
    base_addr  = '0;
    len        = '0;
    act_valid  = 1'b0;
    act_data   = '0;
    build_table();
    limit_cycles = cycle_limit();
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_value("mode_o", MODE_IDLE, mode);
    check_value("busy_o", 0, busy);
    check_value("result_valid_o", 0, result_valid);
    check_value("sram_cs", 0, epu_top_i.weight_wrapper_i.sram_cs);
    check_value("sram_we", 0, epu_top_i.weight_wrapper_i.sram_we);
    cur_mode = MODE_IDLE;
    for (idx = 0; idx < num_entries; idx++) begin
      e = entries[idx];
      case (e.action)
        ACT_START, ACT_DONE: pulse_mode(e);
        ACT_LOAD: load_block(e);
        default: dot_product(e);
      endcase
      @(negedge clk);
      check_value("mode_o", e.exp_mode, mode);
      cur_mode = e.exp_mode;
    end
    $display("Verification passed");
    $finish;
  end

endmodule
